/* source/serial_slave_pkg.sv */
// serial slave package with the frame start code, field widths and default sizes
`default_nettype none

package serial_slave_pkg;

    // start pattern that opens every control frame
    localparam int START_WIDTH = 3;
    localparam logic [START_WIDTH-1:0] START_CODE = 3'b111;

    // read/write bit plus burst bit
    localparam int CTRL_WIDTH = 2;

    // word width of the memory and of the serial data lines
    localparam int DEF_DATA_WIDTH = 32;

    // number of memory words behind one slave
    localparam int DEF_ADDR_DEPTH = 2000;

    // id this slave answers to
    localparam int DEF_SLAVE_ID = 1;

    // slaves sharing the bus, sizes the id field
    localparam int DEF_SLAVES = 3;

endpackage

`default_nettype wire

/* source/slave_if.sv */
// command bus from the frame decoder to the engines, and the engines' memory ports
`default_nettype none

interface cmd_if #(
    parameter int ADDR_WIDTH = $clog2(serial_slave_pkg::DEF_ADDR_DEPTH)
);
    // one-cycle launch pulses
    logic                  rd_start;
    logic                  wr_start;
    // held from the pulse until the engine is done
    logic                  burst;
    logic [ADDR_WIDTH-1:0] addr;
    // engine status
    logic                  rd_busy;
    logic                  rd_bit;
    logic                  wr_busy;

    modport decoder (output rd_start, wr_start, burst, addr, input rd_busy, rd_bit, wr_busy);
    modport reader (input rd_start, burst, addr, output rd_busy, rd_bit);
    modport writer (input wr_start, burst, addr, output wr_busy);
endinterface

interface mem_port_if #(
    parameter int ADDR_WIDTH = $clog2(serial_slave_pkg::DEF_ADDR_DEPTH),
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH
);
    // read port, data returns one cycle after rd_en
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0] rd_data;
    // write port, stored at the edge that sees wr_en
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;

    modport reader (output rd_en, rd_addr, input rd_data);
    modport writer (output wr_en, wr_addr, wr_data);
    modport memory (input rd_en, rd_addr, wr_en, wr_addr, wr_data, output rd_data);
endinterface

`default_nettype wire

/* source/frame_decoder.sv */
// frame decoder that shifts in the control frame, checks start code and id, and launches engines
`default_nettype none

module frame_decoder #(
    parameter int ADDR_WIDTH = $clog2(serial_slave_pkg::DEF_ADDR_DEPTH),
    parameter int S_ID_WIDTH = $clog2(serial_slave_pkg::DEF_SLAVES + 1),
    parameter int SLAVE_ID   = serial_slave_pkg::DEF_SLAVE_ID
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   control,
    output logic   ready,
    cmd_if.decoder cmd
);
    import serial_slave_pkg::*;

    localparam int FRAME_LEN = START_WIDTH + S_ID_WIDTH + CTRL_WIDTH + ADDR_WIDTH;
    localparam int CNT_WIDTH = $clog2(FRAME_LEN);

    // field positions, msb of the frame arrives first
    localparam int START_LSB = FRAME_LEN - START_WIDTH;
    localparam int ID_LSB    = ADDR_WIDTH + CTRL_WIDTH;
    localparam int RW_POS    = ADDR_WIDTH + 1;
    localparam int BURST_POS = ADDR_WIDTH;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SHIFT  = 2'd1;
    localparam logic [1:0] ST_DECODE = 2'd2;
    localparam logic [1:0] ST_WAIT   = 2'd3;

    logic [1:0]           state;
    logic [CNT_WIDTH-1:0] bit_cnt;
    logic [FRAME_LEN-1:0] frame;
    logic                 frame_shift;
    logic                 match;

    assign frame_shift = (state == ST_SHIFT) || ((state == ST_IDLE) && control);

    assign match = (frame[START_LSB +: START_WIDTH] == START_CODE) &&
                   (frame[ID_LSB +: S_ID_WIDTH] == S_ID_WIDTH'(SLAVE_ID));

    // launch pulses come straight out of the decode cycle
    assign cmd.wr_start = (state == ST_DECODE) && match && frame[RW_POS];
    assign cmd.rd_start = (state == ST_DECODE) && match && !frame[RW_POS];
    assign cmd.burst    = frame[BURST_POS];
    assign cmd.addr     = frame[ADDR_WIDTH-1:0];

    // a read marks its bit slots, a write keeps ready high throughout
    always_comb begin
        case (state)
            ST_DECODE: ready = !match;
            ST_WAIT:   ready = cmd.rd_busy ? cmd.rd_bit : 1'b1;
            default:   ready = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (control) begin
                        bit_cnt <= CNT_WIDTH'(1);
                        state   <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_WIDTH'(FRAME_LEN - 1)) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    // a foreign or broken frame is simply dropped
                    state <= match ? ST_WAIT : ST_IDLE;
                end
                default: begin
                    if (!cmd.rd_busy && !cmd.wr_busy) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_shift) begin
            frame <= {frame[FRAME_LEN-2:0], control};
        end
    end

endmodule

`default_nettype wire

/* source/read_serializer.sv */
// read engine that fetches memory words and shifts them out on rd msb first
`default_nettype none

module read_serializer #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH,
    parameter int ADDR_WIDTH = $clog2(serial_slave_pkg::DEF_ADDR_DEPTH)
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       last,
    output logic       rd,
    cmd_if.reader      cmd,
    mem_port_if.reader mem
);
    localparam int CNT_WIDTH = $clog2(DATA_WIDTH);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_SEND  = 2'd2;

    logic [1:0]            state;
    logic [CNT_WIDTH-1:0]  bit_cnt;
    logic                  last_seen;
    logic                  sending;
    logic                  word_done;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH-1:0] addr_next;
    logic [DATA_WIDTH-1:0] shreg;
    logic [DATA_WIDTH-1:0] cur_word;

    assign sending   = (state == ST_SEND);
    assign word_done = sending && (bit_cnt == CNT_WIDTH'(DATA_WIDTH - 1));

    // first bit of a word comes directly from the memory output
    assign cur_word  = (bit_cnt == '0) ? mem.rd_data : shreg;

    // burst addresses wrap at the end of the array
    assign addr_next = (addr_q == ADDR_WIDTH'(ADDR_DEPTH - 1)) ? '0 : addr_q + 1'b1;

    assign rd          = sending & cur_word[DATA_WIDTH-1];
    assign cmd.rd_bit  = sending;
    assign cmd.rd_busy = (state != ST_IDLE);
    assign mem.rd_en   = (state == ST_FETCH);
    assign mem.rd_addr = addr_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            last_seen <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd.rd_start) begin
                        bit_cnt   <= '0;
                        last_seen <= 1'b0;
                        state     <= ST_FETCH;
                    end
                end
                ST_FETCH: state <= ST_SEND;
                ST_SEND: begin
                    if (word_done) begin
                        bit_cnt <= '0;
                        // last at any bit of the word closes the burst
                        if (!cmd.burst || last_seen || last) begin
                            state <= ST_IDLE;
                        end else begin
                            last_seen <= 1'b0;
                            state     <= ST_FETCH;
                        end
                    end else begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        last_seen <= last_seen | last;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && cmd.rd_start) begin
            addr_q <= cmd.addr;
        end else if (word_done) begin
            addr_q <= addr_next;
        end
        if (sending) begin
            shreg <= cur_word << 1;
        end
    end

endmodule

`default_nettype wire

/* source/write_deserializer.sv */
// write engine that collects wd bits into words and stores them in memory
`default_nettype none

module write_deserializer #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH,
    parameter int ADDR_WIDTH = $clog2(serial_slave_pkg::DEF_ADDR_DEPTH)
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wd,
    input  logic       valid,
    input  logic       last,
    cmd_if.writer      cmd,
    mem_port_if.writer mem
);
    localparam int CNT_WIDTH = $clog2(DATA_WIDTH);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_COLLECT = 2'd1;
    localparam logic [1:0] ST_FLUSH   = 2'd2;

    logic [1:0]            state;
    logic [CNT_WIDTH-1:0]  bit_cnt;
    logic                  wr_pend;
    logic                  bit_take;
    logic                  word_end;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH-1:0] addr_next;
    logic [DATA_WIDTH-1:0] shreg;

    assign bit_take  = (state == ST_COLLECT) && valid;
    assign word_end  = bit_take && (bit_cnt == CNT_WIDTH'(DATA_WIDTH - 1));
    assign addr_next = (addr_q == ADDR_WIDTH'(ADDR_DEPTH - 1)) ? '0 : addr_q + 1'b1;

    // the finished word is written one cycle after its last bit,
    // while the next word may already be shifting in
    assign mem.wr_en   = wr_pend;
    assign mem.wr_addr = addr_q;
    assign mem.wr_data = shreg;
    assign cmd.wr_busy = (state != ST_IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= word_end;
            case (state)
                ST_IDLE: begin
                    if (cmd.wr_start) begin
                        bit_cnt <= '0;
                        state   <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    if (word_end) begin
                        bit_cnt <= '0;
                        if (!cmd.burst || last) begin
                            state <= ST_FLUSH;
                        end
                    end else if (bit_take) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                // final word is stored at the end of this cycle
                ST_FLUSH: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && cmd.wr_start) begin
            addr_q <= cmd.addr;
        end else if (wr_pend) begin
            addr_q <= addr_next;
        end
        if (bit_take) begin
            shreg <= {shreg[DATA_WIDTH-2:0], wd};
        end
    end

endmodule

`default_nettype wire

/* source/slave_memory.sv */
// word memory with a registered read port and a write port
`default_nettype none

module slave_memory #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH
) (
    input  logic       clk,
    mem_port_if.memory mem
);
    logic [DATA_WIDTH-1:0] words [ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            words[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read data is valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= words[mem.rd_addr];
        end
    end

endmodule

`default_nettype wire

/* source/serial_slave_top.sv */
// serial bus memory slave top level tying decoder, engines and memory together
`default_nettype none

module serial_slave_top #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH,
    parameter int SLAVES     = serial_slave_pkg::DEF_SLAVES,
    parameter int SLAVE_ID   = serial_slave_pkg::DEF_SLAVE_ID
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);
    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);
    // id field wide enough for every slave plus the unused code
    localparam int S_ID_WIDTH = $clog2(SLAVES + 1);

    cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) cmd_bus ();

    mem_port_if #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) mem_bus ();

    frame_decoder #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .S_ID_WIDTH(S_ID_WIDTH),
        .SLAVE_ID  (SLAVE_ID)
    ) decoder_i (
        .clk    (clk),
        .rstN   (rstN),
        .control(control),
        .ready  (ready),
        .cmd    (cmd_bus.decoder)
    );

    read_serializer #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_DEPTH(ADDR_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) reader_i (
        .clk (clk),
        .rstN(rstN),
        .last(last),
        .rd  (rd),
        .cmd (cmd_bus.reader),
        .mem (mem_bus.reader)
    );

    write_deserializer #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_DEPTH(ADDR_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) writer_i (
        .clk  (clk),
        .rstN (rstN),
        .wd   (wd),
        .valid(valid),
        .last (last),
        .cmd  (cmd_bus.writer),
        .mem  (mem_bus.writer)
    );

    slave_memory #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_DEPTH(ADDR_DEPTH)
    ) memory_i (
        .clk(clk),
        .mem(mem_bus.memory)
    );

endmodule

`default_nettype wire

/* testbench/serial_master_tasks.svh */
// bus master tasks that send control frames, stream write words and collect read words
`ifndef SERIAL_MASTER_TASKS_SVH
`define SERIAL_MASTER_TASKS_SVH

// one bus step with inputs changing just after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

// frame bits go out msb first on consecutive cycles
task automatic send_frame(input logic [FRAME_LEN-1:0] bits);
    for (int i = FRAME_LEN - 1; i >= 0; i--) begin
        control = bits[i];
        next_cycle();
    end
    control = 1'b0;
endtask

// streams wr_buf msb first with random valid gaps and last on the final bit
task automatic write_words();
    int gap;
    int ready_low;
    ready_low = 0;
    // the writer collects from the cycle after the decode cycle
    next_cycle();
    for (int w = 0; w < wr_buf.size(); w++) begin
        for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
            gap = ($urandom % 4 == 0) ? int'($urandom % MAX_GAP) + 1 : 0;
            valid = 1'b0;
            repeat (gap) next_cycle();
            valid = 1'b1;
            wd    = wr_buf[w][b];
            last  = (w == wr_buf.size() - 1) && (b == 0);
            // a busy writer keeps ready high
            if (!ready) begin
                ready_low++;
            end
            next_cycle();
        end
    end
    valid = 1'b0;
    wd    = 1'b0;
    last  = 1'b0;
    // final word is stored two edges on and the decoder is idle one edge later
    repeat (3) next_cycle();
    checks++;
    if (ready_low != 0) begin
        log_error($sformatf("ready low in %0d bit cycles of a write", ready_low));
    end
endtask

// collects count words into rd_buf from the ready-high slots of a read
task automatic read_words(input int count);
    logic [DATA_WIDTH-1:0] word;
    int bits;
    int gaps;
    int cycles;
    int late_low;
    int last_bit;
    rd_buf.delete();
    word     = '0;
    bits     = 0;
    gaps     = 0;
    cycles   = 0;
    late_low = 0;
    // one short last pulse somewhere in the final word closes a burst
    last_bit = (count - 1) * DATA_WIDTH + 1 + int'($urandom % DATA_WIDTH);
    while (bits < count * DATA_WIDTH && cycles < count * (DATA_WIDTH + 1) + 8) begin
        if (ready) begin
            word = {word[DATA_WIDTH-2:0], rd};
            bits++;
            last = (bits == last_bit);
            if (bits % DATA_WIDTH == 0) begin
                rd_buf.push_back(word);
            end
        end else if (bits > 0) begin
            gaps++;
        end
        next_cycle();
        cycles++;
    end
    last = 1'b0;
    if (bits < count * DATA_WIDTH) begin
        $display("read of %0d words gave only %0d bits before giving up", count, bits);
        errors++;
    end
    checks++;
    if (gaps != count - 1) begin
        log_error($sformatf("expected %0d idle slots between words, saw %0d", count - 1, gaps));
    end
    // an extra fetch after the final word would pull ready low here
    for (int i = 0; i < 4; i++) begin
        if (!ready) begin
            late_low++;
        end
        next_cycle();
    end
    checks++;
    if (late_low != 0) begin
        log_error($sformatf("ready low for %0d cycles after the final word", late_low));
    end
endtask

`endif

/* testbench/tb_serial_slave.sv */
// testbench for the serial slave with random single and burst transfers checked against a model
`default_nettype none

module tb_serial_slave;
    timeunit 1ns;
    timeprecision 100ps;

    import serial_slave_pkg::*;

    localparam int DATA_WIDTH   = DEF_DATA_WIDTH;
    localparam int ADDR_DEPTH   = DEF_ADDR_DEPTH;
    localparam int ADDR_WIDTH   = $clog2(ADDR_DEPTH);
    localparam int S_ID_WIDTH   = $clog2(DEF_SLAVES + 1);
    localparam int FRAME_LEN    = 3 + S_ID_WIDTH + 2 + ADDR_WIDTH;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_BURST    = 5;
    localparam int MAX_GAP      = 3;
    localparam int MIX_COUNT    = 50;
    // longest transfer is a full burst write with every bit stalled
    localparam int TXN_CYCLES   = FRAME_LEN + MAX_BURST * DATA_WIDTH * (MAX_GAP + 1) + 16;
    localparam int TXN_COUNT    = 12 + 2 * MIX_COUNT;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TXN_COUNT * TXN_CYCLES;

    logic clk;
    logic rstN;
    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd;
    logic ready;

    int errors;
    int checks;
    int tests;

    logic [DATA_WIDTH-1:0] wr_buf[$];
    logic [DATA_WIDTH-1:0] rd_buf[$];
    // every word written so far, by address
    logic [DATA_WIDTH-1:0] model_mem[int];
    int                    written[$];

    serial_slave_top dut_i (
        .clk    (clk),
        .rstN   (rstN),
        .control(control),
        .wd     (wd),
        .valid  (valid),
        .last   (last),
        .rd     (rd),
        .ready  (ready)
    );

    function automatic void log_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endfunction

    `include "serial_master_tasks.svh"

    function automatic logic [FRAME_LEN-1:0] build_frame(input logic [2:0] start, input int id,
            input logic is_write, input logic burst, input int addr);
        return {start, S_ID_WIDTH'(id), is_write, burst, ADDR_WIDTH'(addr)};
    endfunction

    // start address with room for the whole burst
    function automatic int pick_start(input int count);
        return int'($urandom % (ADDR_DEPTH - count + 1));
    endfunction

    task automatic do_write(input int addr, input int count);
        logic [DATA_WIDTH-1:0] w;
        wr_buf.delete();
        for (int i = 0; i < count; i++) begin
            w = $urandom;
            wr_buf.push_back(w);
            if (!model_mem.exists(addr + i)) begin
                written.push_back(addr + i);
            end
            model_mem[addr + i] = w;
        end
        send_frame(build_frame(START_CODE, DEF_SLAVE_ID, 1'b1, count > 1, addr));
        write_words();
    endtask

    task automatic do_read(input int addr, input int count);
        send_frame(build_frame(START_CODE, DEF_SLAVE_ID, 1'b0, count > 1, addr));
        checks++;
        if (ready !== 1'b0) begin
            log_error("ready stayed high in the decode cycle of a matching frame");
        end
        read_words(count);
        for (int i = 0; i < rd_buf.size(); i++) begin
            checks++;
            if (rd_buf[i] !== model_mem[addr + i]) begin
                log_error($sformatf("read addr %0d got %h expected %h",
                                    addr + i, rd_buf[i], model_mem[addr + i]));
            end
        end
    endtask

    // a foreign frame must leave ready high all the way through
    task automatic send_foreign_frame(input logic [2:0] start, input int id, input logic is_write);
        int low_cycles;
        low_cycles = 0;
        send_frame(build_frame(start, id, is_write, 1'b0, pick_start(1)));
        for (int i = 0; i < 4; i++) begin
            if (!ready) begin
                low_cycles++;
            end
            next_cycle();
        end
        checks++;
        if (low_cycles != 0) begin
            log_error($sformatf("ready low for %0d cycles after a foreign frame", low_cycles));
        end
    endtask

    task automatic run_random_mix();
        int addr;
        int count;
        int run;
        for (int n = 0; n < MIX_COUNT; n++) begin
            if (written.size() == 0 || $urandom % 2 == 0) begin
                count = ($urandom % 2 == 0) ? 1 : 2 + int'($urandom % (MAX_BURST - 1));
                addr  = pick_start(count);
                do_write(addr, count);
            end else begin
                addr = written[$urandom % written.size()];
                run  = 1;
                while (run < MAX_BURST && model_mem.exists(addr + run)) begin
                    run++;
                end
                count = (run > 1 && $urandom % 2 == 0) ? 2 + int'($urandom % (run - 1)) : 1;
                do_read(addr, count);
            end
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout, the run was still going after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int mark;
        int addr;
        int count;
        void'($urandom(32'h30b3));
        rstN    = 1'b0;
        control = 1'b0;
        wd      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        next_cycle();

        mark = errors;
        checks++;
        if (ready !== 1'b1 || rd !== 1'b0) begin
            log_error($sformatf("after reset ready=%b rd=%b, expected 1 and 0", ready, rd));
        end
        end_test("reset", mark);

        mark = errors;
        addr = pick_start(1);
        do_write(addr, 1);
        do_read(addr, 1);
        end_test("single", mark);

        mark  = errors;
        count = 2 + int'($urandom % (MAX_BURST - 1));
        addr  = pick_start(count);
        do_write(addr, count);
        do_read(addr, count);
        end_test("burst", mark);

        // wrong ids come from the other slaves, wrong start codes keep the leading one
        mark = errors;
        send_foreign_frame(START_CODE, (DEF_SLAVE_ID + 1 + int'($urandom % 3)) % 4, 1'b0);
        send_foreign_frame(START_CODE, (DEF_SLAVE_ID + 1 + int'($urandom % 3)) % 4, 1'b1);
        send_foreign_frame(3'(4 + $urandom % 3), DEF_SLAVE_ID, 1'b0);
        do_read(written[$urandom % written.size()], 1);
        end_test("foreign", mark);

        mark = errors;
        run_random_mix();
        end_test("random", mark);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/serial_slave_pkg.sv
source/slave_if.sv
source/frame_decoder.sv
source/read_serializer.sv
source/write_deserializer.sv
source/slave_memory.sv
source/serial_slave_top.sv
+incdir+testbench
testbench/tb_serial_slave.sv

/* run_sim.sh */
#!/bin/sh
# build the serial slave testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f flist.f \
    --top-module tb_serial_slave -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
